/* logic/calcPkg.sv */
package calcPkg;

	//////////////////////////////////////////////////
	// Widths
	//////////////////////////////////////////////////

	// Operand and result width of the processor
	localparam int NUM_WIDTH = 32;

	// 640x480 screen coordinates
	localparam int COORD_X_WIDTH = 10;
	localparam int COORD_Y_WIDTH = 9;

	// Displayed digit count
	localparam int COUNT_WIDTH = 4;

	// One decimal digit
	localparam int DIGIT_WIDTH = 4;

	//////////////////////////////////////////////////
	// Keys and operations
	//////////////////////////////////////////////////

	typedef enum logic [1:0] {kindDigit, kindOperator, kindEquals, kindClear} keyKind_t;

	// Order matches the operator column, top to bottom
	typedef enum logic [1:0] {opAdd, opSub, opMul, opDiv} opCode_t;

	typedef struct packed {
		keyKind_t kind;
		logic [DIGIT_WIDTH-1:0] digit;
		opCode_t op;
	} keyEvent_t;

	//////////////////////////////////////////////////
	// Number entry and processor port
	//////////////////////////////////////////////////

	typedef enum logic [1:0] {cmdAppend, cmdClear, cmdLoad} entryCmdKind_t;

	typedef struct packed {
		entryCmdKind_t kind;
		logic [DIGIT_WIDTH-1:0] digit;
	} entryCmd_t;

	// Register map of the arithmetic processor
	typedef enum logic [1:0] {slotOperandA = 2'd0, slotOpCode = 2'd1, slotOperandB = 2'd2} writeSlot_t;

	typedef struct packed {
		writeSlot_t addr;
		logic [NUM_WIDTH-1:0] data;
	} procWrite_t;

	// Sequencer states
	typedef enum logic [2:0] {stIdle, stOpWrite, stSecond, stRequest, stWait} calcState_t;

endpackage

/* logic/keypadDecoder.sv */
module keypadDecoder import calcPkg::*; #(
	parameter int unsigned KEY_ORIGIN_X = 200,
	parameter int unsigned KEY_ORIGIN_Y = 120,
	parameter int unsigned KEY_SIZE = 40
) (
	input logic CLK50,
	input logic rstN,
	input logic click,
	input logic [COORD_X_WIDTH-1:0] clickX,
	input logic [COORD_Y_WIDTH-1:0] clickY,
	output logic keyValid,
	output keyEvent_t key
);

	// Grid position and extent in screen coordinates
	localparam int unsigned GRID_SPAN = 4 * KEY_SIZE;

	logic insideX;
	logic insideY;
	logic [1:0] row;
	logic [1:0] col;
	keyEvent_t cellKey;

	// Cell index along one axis, position already relative to origin
	function automatic logic [1:0] cellOf(input int unsigned rel, input int unsigned size);
		logic [1:0] idx;
		if (rel >= 3 * size)
			idx = 2'd3;
		else if (rel >= 2 * size)
			idx = 2'd2;
		else if (rel >= size)
			idx = 2'd1;
		else
			idx = 2'd0;
		return idx;
	endfunction

	// Fixed keypad layout
	function automatic keyEvent_t layoutKey(input logic [1:0] r, input logic [1:0] c);
		keyEvent_t k;
		k.kind = kindDigit;
		k.digit = '0;
		k.op = opAdd;
		if (c == 2'd3)
		begin
			// Right column holds the operators
			k.kind = kindOperator;
			k.op = opCode_t'(r);
		end
		else if (r == 2'd3)
		begin
			// Bottom row: clear, 0, equals
			case (c)
				2'd0: k.kind = kindClear;
				2'd1: k.digit = 4'd0;
				default: k.kind = kindEquals;
			endcase
		end
		else
			// 7 8 9 / 4 5 6 / 1 2 3
			k.digit = 4'd7 + {2'b00, c} - 4'd3 * {2'b00, r};
		return k;
	endfunction

	//////////////////////////////////////////////////
	// Hit test and lookup
	//////////////////////////////////////////////////

	always_comb
	begin
		insideX = (clickX >= KEY_ORIGIN_X) && (clickX < KEY_ORIGIN_X + GRID_SPAN);
		insideY = (clickY >= KEY_ORIGIN_Y) && (clickY < KEY_ORIGIN_Y + GRID_SPAN);
		// Only meaningful when inside the grid
		col = cellOf(int'(clickX) - KEY_ORIGIN_X, KEY_SIZE);
		row = cellOf(int'(clickY) - KEY_ORIGIN_Y, KEY_SIZE);
		cellKey = layoutKey(row, col);
	end

	// Strobe one cycle after the click
	always_ff @(posedge CLK50 or negedge rstN)
	begin
		if (!rstN)
			keyValid <= 1'b0;
		else
			keyValid <= click && insideX && insideY;
	end

	// Key payload, held until the next click
	always_ff @(posedge CLK50)
	begin
		if (click)
			key <= cellKey;
	end

endmodule

/* logic/numberEntry.sv */
module numberEntry import calcPkg::*; #(
	parameter int unsigned MAX_DIGITS = 8
) (
	input logic CLK50,
	input logic rstN,
	input logic cmdValid,
	input entryCmd_t cmd,
	input logic [NUM_WIDTH-1:0] resultData,
	output logic [NUM_WIDTH-1:0] value,
	output logic [COUNT_WIDTH-1:0] digitCount
);

	// Digit limit in count width
	localparam logic [COUNT_WIDTH-1:0] DIGIT_LIMIT = COUNT_WIDTH'(MAX_DIGITS);

	// Shown number is a loaded result
	logic fresh;

	logic [NUM_WIDTH-1:0] digitExt;
	logic [NUM_WIDTH-1:0] shifted;
	logic canAppend;

	//////////////////////////////////////////////////
	// Decimal shift
	//////////////////////////////////////////////////

	always_comb
	begin
		digitExt = NUM_WIDTH'(cmd.digit);
		// value * 10 as 8x + 2x
		shifted = (value << 3) + (value << 1) + digitExt;
		canAppend = digitCount < DIGIT_LIMIT;
	end

	//////////////////////////////////////////////////
	// Number register
	//////////////////////////////////////////////////

	always_ff @(posedge CLK50 or negedge rstN)
	begin
		if (!rstN)
		begin
			value <= '0;
			digitCount <= '0;
			fresh <= 1'b0;
		end
		else if (cmdValid)
		begin
			unique case (cmd.kind)
				cmdAppend:
				begin
					if (fresh)
					begin
						// New number replaces the result
						value <= digitExt;
						digitCount <= COUNT_WIDTH'(1);
						fresh <= 1'b0;
					end
					else if (canAppend)
					begin
						value <= shifted;
						digitCount <= digitCount + 1'b1;
					end
					// Digits past the limit dropped
				end
				cmdClear:
				begin
					value <= '0;
					digitCount <= '0;
					fresh <= 1'b0;
				end
				cmdLoad:
				begin
					// Result has no typed digits
					value <= resultData;
					digitCount <= '0;
					fresh <= 1'b1;
				end
			endcase
		end
	end

endmodule

/* logic/calcSequencer.sv */
module calcSequencer import calcPkg::*; (
	input logic CLK50,
	input logic rstN,
	input logic keyValid,
	input keyEvent_t key,
	input logic [NUM_WIDTH-1:0] value,
	input logic resultValid,
	output logic cmdValid,
	output entryCmd_t cmd,
	output logic wrValid,
	output procWrite_t wr,
	output logic resultReq,
	output logic busy
);

	calcState_t state;
	calcState_t stateNext;

	// Operation waiting for its opcode write
	opCode_t pendingOp;
	opCode_t pendingOpNext;

	logic cmdValidNext;
	entryCmd_t cmdNext;
	logic wrValidNext;
	procWrite_t wrNext;
	logic resultReqNext;

	logic isDigit;
	logic isClear;

	//////////////////////////////////////////////////
	// Next state and outputs
	//////////////////////////////////////////////////

	always_comb
	begin
		isDigit = keyValid && (key.kind == kindDigit);
		isClear = keyValid && (key.kind == kindClear);

		stateNext = state;
		pendingOpNext = pendingOp;
		cmdValidNext = 1'b0;
		cmdNext.kind = cmdAppend;
		cmdNext.digit = key.digit;
		wrValidNext = 1'b0;
		wrNext.addr = slotOperandA;
		wrNext.data = value;
		resultReqNext = 1'b0;

		unique case (state)
			stIdle, stSecond:
			begin
				if (isDigit)
					cmdValidNext = 1'b1;
				else if (isClear)
				begin
					cmdValidNext = 1'b1;
					cmdNext.kind = cmdClear;
					stateNext = stIdle;
				end
				else if (keyValid && key.kind == kindOperator && state == stIdle)
				begin
					// Shown number becomes operand A
					wrValidNext = 1'b1;
					pendingOpNext = key.op;
					stateNext = stOpWrite;
				end
				else if (keyValid && key.kind == kindEquals && state == stSecond)
				begin
					wrValidNext = 1'b1;
					wrNext.addr = slotOperandB;
					stateNext = stRequest;
				end
				// Equals without operator ignored
			end
			stOpWrite:
			begin
				// Opcode write plus display clear
				wrValidNext = 1'b1;
				wrNext.addr = slotOpCode;
				wrNext.data = NUM_WIDTH'(pendingOp);
				cmdValidNext = 1'b1;
				cmdNext.kind = cmdClear;
				stateNext = isClear ? stIdle : stSecond;
			end
			stRequest:
			begin
				resultReqNext = 1'b1;
				stateNext = stWait;
			end
			stWait:
			begin
				// Keys dropped until the answer
				if (resultValid)
				begin
					cmdValidNext = 1'b1;
					cmdNext.kind = cmdLoad;
					stateNext = stIdle;
				end
			end
			default:
			begin
				stateNext = stIdle;
			end
		endcase
	end

	//////////////////////////////////////////////////
	// Registers
	//////////////////////////////////////////////////

	always_ff @(posedge CLK50 or negedge rstN)
	begin
		if (!rstN)
		begin
			state <= stIdle;
			pendingOp <= opAdd;
			cmdValid <= 1'b0;
			wrValid <= 1'b0;
			resultReq <= 1'b0;
		end
		else
		begin
			state <= stateNext;
			pendingOp <= pendingOpNext;
			cmdValid <= cmdValidNext;
			wrValid <= wrValidNext;
			resultReq <= resultReqNext;
		end
	end

	// Payloads qualified by their strobes
	always_ff @(posedge CLK50)
	begin
		cmd <= cmdNext;
		wr <= wrNext;
	end

	// Waiting on the processor
	assign busy = (state == stWait);

endmodule

/* logic/calculatorCore.sv */
module calculatorCore import calcPkg::*; #(
	parameter int unsigned KEY_ORIGIN_X = 200,
	parameter int unsigned KEY_ORIGIN_Y = 120,
	parameter int unsigned KEY_SIZE = 40,
	parameter int unsigned MAX_DIGITS = 8
) (
	input logic CLK50,
	input logic rstN,
	input logic click,
	input logic [COORD_X_WIDTH-1:0] clickX,
	input logic [COORD_Y_WIDTH-1:0] clickY,
	input logic resultValid,
	input logic [NUM_WIDTH-1:0] resultData,
	output logic wrValid,
	output procWrite_t wr,
	output logic resultReq,
	output logic busy,
	output logic [NUM_WIDTH-1:0] value,
	output logic [COUNT_WIDTH-1:0] digitCount
);

	// Decoder to sequencer
	logic keyValid;
	keyEvent_t key;

	// Sequencer to number entry
	logic cmdValid;
	entryCmd_t cmd;

	//////////////////////////////////////////////////
	// Click to key
	//////////////////////////////////////////////////

	keypadDecoder #(
		.KEY_ORIGIN_X(KEY_ORIGIN_X),
		.KEY_ORIGIN_Y(KEY_ORIGIN_Y),
		.KEY_SIZE(KEY_SIZE)
	) u_keypadDecoder (
		.CLK50(CLK50),
		.rstN(rstN),
		.click(click),
		.clickX(clickX),
		.clickY(clickY),
		.keyValid(keyValid),
		.key(key)
	);

	// Key routing and processor handshake
	calcSequencer u_calcSequencer (
		.CLK50(CLK50),
		.rstN(rstN),
		.keyValid(keyValid),
		.key(key),
		.value(value),
		.resultValid(resultValid),
		.cmdValid(cmdValid),
		.cmd(cmd),
		.wrValid(wrValid),
		.wr(wr),
		.resultReq(resultReq),
		.busy(busy)
	);

	// Displayed number
	numberEntry #(
		.MAX_DIGITS(MAX_DIGITS)
	) u_numberEntry (
		.CLK50(CLK50),
		.rstN(rstN),
		.cmdValid(cmdValid),
		.cmd(cmd),
		.resultData(resultData),
		.value(value),
		.digitCount(digitCount)
	);

endmodule

/* dv/calcChecks.svh */
`ifndef CALC_CHECKS_SVH
`define CALC_CHECKS_SVH

//////////////////////////////////////////////////
// Failure and compare tasks
//////////////////////////////////////////////////

// Report, print the verdict, stop
task automatic failRun(input string msg);
	$display("%s", msg);
	$display("Test failed");
	$fatal(1, "stopping at first error");
endtask

// Shown number and its digit count
task automatic checkValue(input string name, input logic [NUM_WIDTH-1:0] expVal,
	input logic [COUNT_WIDTH-1:0] expCount);
	if (value !== expVal || digitCount !== expCount)
		failRun($sformatf("CHECK FAILED %s: expected value %0d count %0d, actual value %0d count %0d",
			name, expVal, expCount, value, digitCount));
endtask

// One write to the processor
task automatic checkWrite(input string name, input procWrite_t expected, input procWrite_t actual);
	if (expected !== actual)
		failRun($sformatf("CHECK FAILED %s: expected slot %0d data %0d, actual slot %0d data %0d",
			name, expected.addr, expected.data, actual.addr, actual.data));
endtask

task automatic checkBusy(input string name, input logic expected);
	if (busy !== expected)
		failRun($sformatf("CHECK FAILED %s: expected busy %0b, actual busy %0b",
			name, expected, busy));
endtask

//////////////////////////////////////////////////
// Waiting with a limit
//////////////////////////////////////////////////

task automatic nextCycle();
	@(posedge CLK50);
	#1;
endtask

// Until n writes are logged
task automatic waitWrites(input int n, input string name);
	int cycles;
	cycles = 0;
	while (writeLog.size() < n)
	begin
		if (cycles == WAIT_LIMIT)
			failRun($sformatf("%s: the core never issued the expected processor write", name));
		nextCycle();
		cycles++;
	end
endtask

task automatic waitBusy(input logic level, input string name);
	int cycles;
	cycles = 0;
	while (busy !== level)
	begin
		if (cycles == WAIT_LIMIT)
			failRun($sformatf("%s: busy did not change to %0b in time", name, level));
		nextCycle();
		cycles++;
	end
endtask

//////////////////////////////////////////////////
// Clicks on the keypad
//////////////////////////////////////////////////

// One-cycle click, then wait until number entry has acted
task automatic clickAt(input logic [COORD_X_WIDTH-1:0] x, input logic [COORD_Y_WIDTH-1:0] y);
	click = 1'b1;
	clickX = x;
	clickY = y;
	nextCycle();
	click = 1'b0;
	repeat (2) @(posedge CLK50);
	#1;
endtask

// Center of one cell
task automatic pressCell(input int row, input int col);
	clickAt(COORD_X_WIDTH'(KEY_ORIGIN_X + col * KEY_SIZE + KEY_SIZE / 2),
		COORD_Y_WIDTH'(KEY_ORIGIN_Y + row * KEY_SIZE + KEY_SIZE / 2));
endtask

task automatic pressDigit(input logic [DIGIT_WIDTH-1:0] d);
	// 0 sits in the bottom row, 1 to 9 count upward from row 2
	if (d == 0)
		pressCell(3, 1);
	else
		pressCell(2 - (int'(d) - 1) / 3, (int'(d) - 1) % 3);
endtask

task automatic pressOperator(input opCode_t op);
	pressCell(int'(op), 3);
endtask

task automatic pressEquals();
	pressCell(3, 2);
endtask

task automatic pressClear();
	pressCell(3, 0);
endtask

`endif

/* dv/calcTb.sv */
module calcTb import calcPkg::*; ();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int CLK_PERIOD = 8;
	localparam int KEY_ORIGIN_X = 200;
	localparam int KEY_ORIGIN_Y = 120;
	localparam int KEY_SIZE = 40;
	localparam int MAX_DIGITS = 8;

	// Cycle budget for the watchdog
	localparam int CLICK_CYCLES = 4;
	// Equals, request, answer delay up to 4, load
	localparam int RESULT_CYCLES = 8;
	// Clear, two 4-digit operands, operator, equals, busy click
	localparam int CALC_CYCLES = 12 * CLICK_CYCLES + RESULT_CYCLES + 4;
	// Tests 1 to 3 as clicks and tests 4 and 5 as calculations
	localparam int RUN_CYCLES = 5 + 25 * CLICK_CYCLES + 7 * CALC_CYCLES;
	localparam int WATCHDOG_NS = 2 * RUN_CYCLES * CLK_PERIOD;
	localparam int WAIT_LIMIT = 16;

	logic CLK50;
	logic rstN;
	logic click;
	logic [COORD_X_WIDTH-1:0] clickX;
	logic [COORD_Y_WIDTH-1:0] clickY;
	logic resultValid;
	logic [NUM_WIDTH-1:0] resultData;
	logic wrValid;
	procWrite_t wr;
	logic resultReq;
	logic busy;
	logic [NUM_WIDTH-1:0] value;
	logic [COUNT_WIDTH-1:0] digitCount;

	// Processor registers and every write seen
	logic [NUM_WIDTH-1:0] slotA;
	logic [NUM_WIDTH-1:0] slotB;
	opCode_t slotOp;
	procWrite_t writeLog[$];

	integer seed = 32'h553a;

	`include "calcChecks.svh"

	calculatorCore #(
		.KEY_ORIGIN_X(KEY_ORIGIN_X),
		.KEY_ORIGIN_Y(KEY_ORIGIN_Y),
		.KEY_SIZE(KEY_SIZE),
		.MAX_DIGITS(MAX_DIGITS)
	) u_calculatorCore (
		.CLK50(CLK50),
		.rstN(rstN),
		.click(click),
		.clickX(clickX),
		.clickY(clickY),
		.resultValid(resultValid),
		.resultData(resultData),
		.wrValid(wrValid),
		.wr(wr),
		.resultReq(resultReq),
		.busy(busy),
		.value(value),
		.digitCount(digitCount)
	);

	always #(CLK_PERIOD / 2) CLK50 = ~CLK50;

	//////////////////////////////////////////////////
	// Arithmetic processor model
	//////////////////////////////////////////////////

	// Modulo 2^32, unsigned quotient, 0 on a zero divisor
	function automatic logic [NUM_WIDTH-1:0] expectedResult(input logic [NUM_WIDTH-1:0] a,
		input opCode_t op, input logic [NUM_WIDTH-1:0] b);
		case (op)
			opAdd: return a + b;
			opSub: return a - b;
			opMul: return a * b;
			default: return (b == 0) ? '0 : a / b;
		endcase
	endfunction

	// Strobes sampled mid-cycle
	always @(negedge CLK50)
	begin
		if (rstN && wrValid)
		begin
			case (wr.addr)
				slotOperandA: slotA = wr.data;
				slotOpCode: slotOp = opCode_t'(wr.data[1:0]);
				default: slotB = wr.data;
			endcase
			writeLog.push_back(wr);
		end
	end

	initial
	begin
		int delay;
		logic [NUM_WIDTH-1:0] answer;
		resultValid = 1'b0;
		resultData = '0;
		forever
		begin
			@(negedge CLK50);
			if (rstN && resultReq)
			begin
				// Answer 1 to 4 cycles later
				delay = 1 + int'($unsigned($random(seed)) % 4);
				answer = expectedResult(slotA, slotOp, slotB);
				repeat (delay) @(posedge CLK50);
				#1;
				resultValid = 1'b1;
				resultData = answer;
				nextCycle();
				resultValid = 1'b0;
			end
		end
	end

	//////////////////////////////////////////////////
	// Test helpers
	//////////////////////////////////////////////////

	function automatic procWrite_t makeWrite(input writeSlot_t addr, input logic [NUM_WIDTH-1:0] data);
		procWrite_t w;
		w.addr = addr;
		w.data = data;
		return w;
	endfunction

	function automatic logic [COUNT_WIDTH-1:0] digitsIn(input logic [NUM_WIDTH-1:0] n);
		string s;
		s = $sformatf("%0d", n);
		return COUNT_WIDTH'(s.len());
	endfunction

	// Most significant digit first
	task automatic enterNumber(input logic [NUM_WIDTH-1:0] n);
		string s;
		byte ch;
		s = $sformatf("%0d", n);
		for (int i = 0; i < s.len(); i++)
		begin
			ch = s[i];
			pressDigit(DIGIT_WIDTH'(ch - 8'h30));
		end
	endtask

	// Operand A write, opcode write, display cleared
	task automatic applyOperator(input string name, input logic [NUM_WIDTH-1:0] a, input opCode_t op);
		logic [NUM_WIDTH-1:0] opData;
		opData = '0;
		opData[1:0] = op;
		pressOperator(op);
		waitWrites(2, name);
		checkWrite(name, makeWrite(slotOperandA, a), writeLog.pop_front());
		checkWrite(name, makeWrite(slotOpCode, opData), writeLog.pop_front());
		nextCycle();
		checkValue(name, '0, '0);
	endtask

	task automatic startOperation(input string name, input logic [NUM_WIDTH-1:0] a, input opCode_t op);
		enterNumber(a);
		checkValue(name, a, digitsIn(a));
		applyOperator(name, a, op);
	endtask

	// Equals through to the loaded answer
	task automatic finishCalc(input string name, input logic [NUM_WIDTH-1:0] b,
		input logic [NUM_WIDTH-1:0] expected);
		pressEquals();
		waitWrites(1, name);
		checkWrite(name, makeWrite(slotOperandB, b), writeLog.pop_front());
		// Request one cycle after the operand B write
		checkBusy(name, 1'b1);
		if (resultReq !== 1'b1)
			failRun($sformatf("%s: the core did not request the result after operand B", name));
		// Digit clicked while the answer is pending
		pressDigit(4'd9);
		// Operand B still shown unless the answer is already loaded
		if (value !== expected || digitCount !== '0)
			checkValue(name, b, digitsIn(b));
		waitBusy(1'b0, name);
		nextCycle();
		checkValue(name, expected, '0);
		if (writeLog.size() != 0)
			failRun($sformatf("%s: the core wrote to the processor after equals", name));
	endtask

	task automatic runCalc(input string name, input logic [NUM_WIDTH-1:0] a, input opCode_t op,
		input logic [NUM_WIDTH-1:0] b);
		pressClear();
		startOperation(name, a, op);
		enterNumber(b);
		finishCalc(name, b, expectedResult(a, op, b));
	endtask

	//////////////////////////////////////////////////
	// Directed tests
	//////////////////////////////////////////////////

	task automatic testDigitEntry();
		pressDigit(4'd4);
		pressDigit(4'd2);
		pressDigit(4'd7);
		// Just right of the grid, then above and left of it
		clickAt(COORD_X_WIDTH'(KEY_ORIGIN_X + 4 * KEY_SIZE), COORD_Y_WIDTH'(KEY_ORIGIN_Y + 10));
		clickAt(COORD_X_WIDTH'(20), COORD_Y_WIDTH'(20));
		checkValue("digit entry", 32'd427, 4'd3);
	endtask

	task automatic testDigitLimit();
		logic [NUM_WIDTH-1:0] expected;
		expected = '0;
		pressClear();
		for (int d = 1; d <= 9; d++)
		begin
			pressDigit(DIGIT_WIDTH'(d));
			if (d <= MAX_DIGITS)
				expected = expected * 10 + NUM_WIDTH'(d);
		end
		checkValue("digit limit", expected, COUNT_WIDTH'(MAX_DIGITS));
	endtask

	task automatic testOperatorWrites();
		pressClear();
		startOperation("operator writes", 32'd12, opAdd);
	endtask

	task automatic testCalculations();
		logic [NUM_WIDTH-1:0] a;
		logic [NUM_WIDTH-1:0] b;
		opCode_t op;
		for (int i = 0; i < 4; i++)
		begin
			op = opCode_t'(i[1:0]);
			a = $unsigned($random(seed)) % 10000;
			b = $unsigned($random(seed)) % 10000;
			runCalc($sformatf("calc %s", op.name()), a, op, b);
		end
		a = $unsigned($random(seed)) % 10000;
		runCalc("divide by zero", a, opDiv, '0);
	endtask

	task automatic testChainAndClear();
		logic [NUM_WIDTH-1:0] prior;
		prior = expectedResult(32'd125, opMul, 32'd8);
		runCalc("chain and clear", 32'd125, opMul, 32'd8);
		// Loaded result goes out as operand A
		applyOperator("chain and clear", prior, opSub);
		enterNumber(32'd7);
		finishCalc("chain and clear", 32'd7, expectedResult(prior, opSub, 32'd7));
		pressClear();
		checkValue("chain and clear", '0, '0);
		checkBusy("chain and clear", 1'b0);
		repeat (4) nextCycle();
		if (writeLog.size() != 0)
			failRun("chain and clear: the clear key caused a processor write");
	endtask

	//////////////////////////////////////////////////
	// Run
	//////////////////////////////////////////////////

	initial
	begin
		#(WATCHDOG_NS);
		failRun($sformatf("Watchdog expired after %0d ns, the tests did not finish", WATCHDOG_NS));
	end

	initial
	begin
		CLK50 = 1'b0;
		rstN = 1'b0;
		click = 1'b0;
		clickX = '0;
		clickY = '0;
		repeat (5) @(posedge CLK50);
		#1;
		rstN = 1'b1;
		nextCycle();
		checkValue("reset", '0, '0);
		checkBusy("reset", 1'b0);
		testDigitEntry();
		testDigitLimit();
		testOperatorWrites();
		testCalculations();
		testChainAndClear();
		$display("Test passed");
		$finish;
	end

endmodule

/* sources.f */
logic/calcPkg.sv
logic/keypadDecoder.sv
logic/numberEntry.sv
logic/calcSequencer.sv
logic/calculatorCore.sv
+incdir+dv
dv/calcTb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the calculator core testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing -Wno-fatal -f sources.f --top-module calcTb \
	--Mdir "$BUILD_DIR" -o calcSim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

"$BUILD_DIR/calcSim" > "$LOG" 2>&1
simStatus=$?
cat "$LOG"

if grep -q "Test failed" "$LOG"; then
	echo "Simulation reported a failure, see $LOG"
	exit 1
fi
if [ $simStatus -ne 0 ]; then
	echo "Simulation exited with status $simStatus"
	exit 1
fi
if ! grep -q "Test passed" "$LOG"; then
	echo "Simulation ended without a result line"
	exit 1
fi
exit 0
